// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = aipWrapperTb
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Test run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: common/aipPkg.sv
package aipPkg;

  // Host and memory word size
  localparam int DataWidth = 32;
  localparam int ConfigWidth = 5;

  // Address field carried in the low bits of the host data word
  localparam int MaxAddrWidth = 16;

  typedef logic [DataWidth-1:0] data_t;

  localparam data_t IpId = 32'h1000500A;

  // Host configuration codes
  typedef enum logic [ConfigWidth-1:0] {
    CodeMemInData  = 5'd0,
    CodeMemInAddr  = 5'd1,
    CodeMemOutData = 5'd2,
    CodeMemOutAddr = 5'd3,
    CodeConfData   = 5'd4,
    CodeConfAddr   = 5'd5,
    CodeStatus     = 5'd30,
    CodeId         = 5'd31
  } configCode_e;

  // Host read source
  typedef enum logic [1:0] {
    SelMemOut = 2'd0,
    SelNone   = 2'd1,
    SelStatus = 2'd2,
    SelId     = 2'd3
  } readSel_e;

  // Status word layout
  localparam int StatusBusyBit = 0;
  localparam int StatusMaskBit = 8;
  localparam int StatusDoneBit = 16;

endpackage

// File: compile.f
common/aipPkg.sv
ram/aipDualPortRam.sv
rtl/aipCtrl.sv
rtl/aipConfigBank.sv
rtl/aipReadback.sv
rtl/aipWrapper.sv
verif/aipCtrl_assert.sv
verif/aipWrapperTb.sv

// File: ram/aipDualPortRam.sv
`timescale 1ns/1ps

module aipDualPortRam #(
  parameter int AddrWidth = 5
) (
  input  logic                 clk,
  input  logic                 wrEn_i,
  input  logic [AddrWidth-1:0] wrAddr_i,
  input  aipPkg::data_t        wrData_i,
  input  logic [AddrWidth-1:0] rdAddr_i,
  output aipPkg::data_t        rdData_o
);
  import aipPkg::*;

  data_t mem [2**AddrWidth];

  always_ff @(posedge clk) begin
    if (wrEn_i) begin
      mem[wrAddr_i] <= wrData_i;
    end
  end

  // Asynchronous read
  assign rdData_o = mem[rdAddr_i];

endmodule

// File: rtl/aipConfigBank.sv
`timescale 1ns/1ps

module aipConfigBank #(
  parameter int ConfRegCount = 2,
  localparam int ConfAddrWidth = (ConfRegCount > 1) ? $clog2(ConfRegCount) : 1
) (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      wrEn_i,
  input  logic [ConfAddrWidth-1:0]                  wrAddr_i,
  input  aipPkg::data_t                             wrData_i,
  output logic [ConfRegCount*aipPkg::DataWidth-1:0] confData_o
);
  import aipPkg::*;

  data_t confRegs [ConfRegCount];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < ConfRegCount; i++) begin
        confRegs[i] <= '0;
      end
    end else if (wrEn_i && (int'(wrAddr_i) < ConfRegCount)) begin
      confRegs[wrAddr_i] <= wrData_i;  // Out-of-range index dropped
    end
  end

  // Word 0 in the low bits
  always_comb begin
    for (int i = 0; i < ConfRegCount; i++) begin
      confData_o[i*DataWidth +: DataWidth] = confRegs[i];
    end
  end

endmodule

// File: rtl/aipCtrl.sv
`timescale 1ns/1ps

module aipCtrl #(
  parameter int MemInAddrWidth = 5,
  parameter int MemOutAddrWidth = 6,
  parameter int ConfRegCount = 2,
  localparam int ConfAddrWidth = (ConfRegCount > 1) ? $clog2(ConfRegCount) : 1
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            en_i,
  input  aipPkg::configCode_e             config_i,
  input  logic                            write_i,
  input  logic                            read_i,
  input  logic [aipPkg::MaxAddrWidth-1:0] addr_i,
  output logic                            memInWrEn_o,
  output logic [MemInAddrWidth-1:0]       memInWrAddr_o,
  output logic [MemOutAddrWidth-1:0]      memOutRdAddr_o,
  output logic                            confWrEn_o,
  output logic [ConfAddrWidth-1:0]        confWrAddr_o,
  output logic                            statusWrEn_o,
  output aipPkg::readSel_e                readSel_o
);
  import aipPkg::*;

  localparam logic [ConfAddrWidth-1:0] ConfLast = ConfAddrWidth'(ConfRegCount - 1);

  logic [MemInAddrWidth-1:0]  memInPtr;
  logic [MemOutAddrWidth-1:0] memOutPtr;
  logic [ConfAddrWidth-1:0]   confPtr;

  logic memInAddrSet;
  logic memOutAddrSet;
  logic memOutRead;
  logic confAddrSet;

  // Write strobes decoded from the code
  assign memInWrEn_o   = write_i && (config_i == CodeMemInData);
  assign confWrEn_o    = write_i && (config_i == CodeConfData);
  assign statusWrEn_o  = write_i && (config_i == CodeStatus);
  assign memInAddrSet  = write_i && (config_i == CodeMemInAddr);
  assign memOutAddrSet = write_i && (config_i == CodeMemOutAddr);
  assign confAddrSet   = write_i && (config_i == CodeConfAddr);
  assign memOutRead    = read_i && (config_i == CodeMemOutData);

  always_comb begin
    case (config_i)
      CodeMemOutData: readSel_o = SelMemOut;
      CodeStatus:     readSel_o = SelStatus;
      CodeId:         readSel_o = SelId;
      default:        readSel_o = SelNone;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      memInPtr  <= '0;
      memOutPtr <= '0;
      confPtr   <= '0;
    end else if (en_i) begin
      if (memInAddrSet) begin
        memInPtr <= addr_i[MemInAddrWidth-1:0];
      end else if (memInWrEn_o) begin
        memInPtr <= memInPtr + MemInAddrWidth'(1);  // Wraps at depth
      end

      if (memOutAddrSet) begin
        memOutPtr <= addr_i[MemOutAddrWidth-1:0];
      end else if (memOutRead) begin
        memOutPtr <= memOutPtr + MemOutAddrWidth'(1);
      end

      if (confAddrSet) begin
        confPtr <= addr_i[ConfAddrWidth-1:0];
      end else if (confWrEn_o) begin
        // Back to word 0 after the last register
        if (confPtr >= ConfLast) begin
          confPtr <= '0;
        end else begin
          confPtr <= confPtr + ConfAddrWidth'(1);
        end
      end
    end
  end

  assign memInWrAddr_o  = memInPtr;
  assign memOutRdAddr_o = memOutPtr;
  assign confWrAddr_o   = confPtr;

endmodule

// File: rtl/aipReadback.sv
`timescale 1ns/1ps

module aipReadback (
  input  logic             clk,
  input  logic             rst,
  input  logic             statusWrEn_i,
  input  aipPkg::data_t    data_i,
  input  aipPkg::readSel_e readSel_i,
  input  aipPkg::data_t    memOutData_i,
  input  logic             coreBusy_i,
  input  logic             coreDone_i,
  output aipPkg::data_t    dataOut_o,
  output logic             intAIP_o
);
  import aipPkg::*;

  logic  maskReg;
  logic  doneReg;
  logic  intReg;
  data_t statusWord;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      maskReg <= 1'b0;
    end else if (statusWrEn_i) begin
      maskReg <= data_i[StatusMaskBit];
    end
  end

  // Set by the core, cleared by the host
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      doneReg <= 1'b0;
    end else if (coreDone_i) begin
      doneReg <= 1'b1;  // Core wins over a clear
    end else if (statusWrEn_i && data_i[StatusDoneBit]) begin
      doneReg <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      intReg <= 1'b0;
    end else begin
      intReg <= doneReg & maskReg;
    end
  end

  assign intAIP_o = intReg;

  always_comb begin
    statusWord = '0;
    statusWord[StatusBusyBit] = coreBusy_i;
    statusWord[StatusMaskBit] = maskReg;
    statusWord[StatusDoneBit] = doneReg;
  end

  // Host read mux
  always_comb begin
    case (readSel_i)
      SelMemOut: dataOut_o = memOutData_i;
      SelStatus: dataOut_o = statusWord;
      SelId:     dataOut_o = IpId;
      default:   dataOut_o = '0;
    endcase
  end

endmodule

// File: rtl/aipWrapper.sv
`timescale 1ns/1ps

module aipWrapper #(
  parameter int MemInAddrWidth = 5,
  parameter int MemOutAddrWidth = 6,
  parameter int ConfRegCount = 2
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  en_i,
  input  aipPkg::configCode_e                   config_i,
  input  aipPkg::data_t                         data_i,
  input  logic                                  write_i,
  input  logic                                  read_i,
  input  logic                                  start_i,
  input  logic [MemInAddrWidth-1:0]             memInRdAddr_i,
  input  logic                                  memOutWrEn_i,
  input  logic [MemOutAddrWidth-1:0]            memOutWrAddr_i,
  input  aipPkg::data_t                         memOutWrData_i,
  input  logic                                  coreBusy_i,
  input  logic                                  coreDone_i,
  output aipPkg::data_t                         dataOut_o,
  output logic                                  intAIP_o,
  output aipPkg::data_t                         memInRdData_o,
  output logic [ConfRegCount*aipPkg::DataWidth-1:0] confData_o,
  output logic                                  coreStart_o
);
  import aipPkg::*;

  localparam int ConfAddrWidth = (ConfRegCount > 1) ? $clog2(ConfRegCount) : 1;

  logic                       memInWrEn;
  logic [MemInAddrWidth-1:0]  memInWrAddr;
  logic [MemOutAddrWidth-1:0] memOutRdAddr;
  data_t                      memOutData;
  logic                       confWrEn;
  logic [ConfAddrWidth-1:0]   confWrAddr;
  logic                       statusWrEn;
  readSel_e                   readSel;

  assign coreStart_o = start_i;  // Start goes straight to the core

  aipCtrl #(
    .MemInAddrWidth (MemInAddrWidth),
    .MemOutAddrWidth(MemOutAddrWidth),
    .ConfRegCount   (ConfRegCount)
  ) ctrl_inst (
    .clk           (clk),
    .rst           (rst),
    .en_i          (en_i),
    .config_i      (config_i),
    .write_i       (write_i),
    .read_i        (read_i),
    .addr_i        (data_i[MaxAddrWidth-1:0]),
    .memInWrEn_o   (memInWrEn),
    .memInWrAddr_o (memInWrAddr),
    .memOutRdAddr_o(memOutRdAddr),
    .confWrEn_o    (confWrEn),
    .confWrAddr_o  (confWrAddr),
    .statusWrEn_o  (statusWrEn),
    .readSel_o     (readSel)
  );

  // Host fills, core reads
  aipDualPortRam #(
    .AddrWidth(MemInAddrWidth)
  ) memIn_inst (
    .clk     (clk),
    .wrEn_i  (memInWrEn),
    .wrAddr_i(memInWrAddr),
    .wrData_i(data_i),
    .rdAddr_i(memInRdAddr_i),
    .rdData_o(memInRdData_o)
  );

  // Core fills, host drains
  aipDualPortRam #(
    .AddrWidth(MemOutAddrWidth)
  ) memOut_inst (
    .clk     (clk),
    .wrEn_i  (memOutWrEn_i),
    .wrAddr_i(memOutWrAddr_i),
    .wrData_i(memOutWrData_i),
    .rdAddr_i(memOutRdAddr),
    .rdData_o(memOutData)
  );

  aipConfigBank #(
    .ConfRegCount(ConfRegCount)
  ) confBank_inst (
    .clk       (clk),
    .rst       (rst),
    .wrEn_i    (confWrEn),
    .wrAddr_i  (confWrAddr),
    .wrData_i  (data_i),
    .confData_o(confData_o)
  );

  aipReadback readback_inst (
    .clk         (clk),
    .rst         (rst),
    .statusWrEn_i(statusWrEn),
    .data_i      (data_i),
    .readSel_i   (readSel),
    .memOutData_i(memOutData),
    .coreBusy_i  (coreBusy_i),
    .coreDone_i  (coreDone_i),
    .dataOut_o   (dataOut_o),
    .intAIP_o    (intAIP_o)
  );

endmodule

// File: verif/aipCtrl_assert.sv
`timescale 1ns/1ps

module aipCtrl_assert #(
  parameter int MemInAddrWidth = 5,
  parameter int MemOutAddrWidth = 6,
  parameter int ConfAddrWidth = 1
) (
  input logic                       clk,
  input logic                       rst,
  input logic                       en_i,
  input aipPkg::configCode_e        config_i,
  input logic                       write_i,
  input logic                       memInWrEn_i,
  input logic                       confWrEn_i,
  input logic                       statusWrEn_i,
  input aipPkg::readSel_e           readSel_i,
  input logic [MemInAddrWidth-1:0]  memInPtr_i,
  input logic [MemOutAddrWidth-1:0] memOutPtr_i,
  input logic [ConfAddrWidth-1:0]   confPtr_i
);
  import aipPkg::*;

  noWriteStrobe: assert property (@(posedge clk) disable iff (!rst)
    !write_i |-> !(memInWrEn_i || confWrEn_i || statusWrEn_i))
    else $error("Write enable high without write_i");

  idSelect: assert property (@(posedge clk) disable iff (!rst)
    (config_i == CodeId) |-> (readSel_i == SelId))
    else $error("Identifier code did not select the identifier");

  // No pointer moves on an edge where en_i is low
  pointerHold: assert property (@(posedge clk) disable iff (!rst)
    !en_i |=> ($stable(memInPtr_i) && $stable(memOutPtr_i) && $stable(confPtr_i)))
    else $error("Address pointer changed while en_i was low");

endmodule

bind aipCtrl aipCtrl_assert #(
  .MemInAddrWidth (MemInAddrWidth),
  .MemOutAddrWidth(MemOutAddrWidth),
  .ConfAddrWidth  (ConfAddrWidth)
) ctrlAssert_inst (
  .clk         (clk),
  .rst         (rst),
  .en_i        (en_i),
  .config_i    (config_i),
  .write_i     (write_i),
  .memInWrEn_i (memInWrEn_o),
  .confWrEn_i  (confWrEn_o),
  .statusWrEn_i(statusWrEn_o),
  .readSel_i   (readSel_o),
  .memInPtr_i  (memInPtr),
  .memOutPtr_i (memOutPtr),
  .confPtr_i   (confPtr)
);

// File: verif/aipWrapperTb.sv
`timescale 1ns/1ps

module aipWrapperTb;
  import aipPkg::*;

  localparam int MemInAddrWidth = 5;
  localparam int MemOutAddrWidth = 6;
  localparam int ConfRegCount = 2;
  localparam int MemInDepth = 2**MemInAddrWidth;
  localparam int ClkPeriod = 40;
  localparam int IntTimeout = 10;
  localparam int RandSeed = 16278;
  localparam data_t ExpectedId = 32'h1000500A;

  // Table operations
  typedef enum {
    OpWrite, OpRead, OpReadNext, OpCoreRead, OpCoreWrite, OpCheckConf,
    OpBusy, OpDone, OpEnable, OpStart, OpCheckInt, OpWaitInt
  } op_e;

  logic clk = 1'b0;
  logic rst;
  logic en;
  configCode_e hostConfig;
  data_t hostData;
  logic hostWrite;
  logic hostRead;
  logic start;
  logic [MemInAddrWidth-1:0] memInRdAddr;
  logic memOutWrEn;
  logic [MemOutAddrWidth-1:0] memOutWrAddr;
  data_t memOutWrData;
  logic coreBusy;
  logic coreDone;
  data_t dataOut;
  logic intAIP;
  data_t memInRdData;
  logic [ConfRegCount*DataWidth-1:0] confData;
  logic coreStart;

  // Columns: operation, code, address or index, data, expected
  op_e opQ [$];
  configCode_e codeQ [$];
  logic [15:0] addrQ [$];
  data_t dataQ [$];
  data_t expQ [$];

  aipWrapper #(
    .MemInAddrWidth (MemInAddrWidth),
    .MemOutAddrWidth(MemOutAddrWidth),
    .ConfRegCount   (ConfRegCount)
  ) aipWrapper_inst (
    .clk           (clk),
    .rst           (rst),
    .en_i          (en),
    .config_i      (hostConfig),
    .data_i        (hostData),
    .write_i       (hostWrite),
    .read_i        (hostRead),
    .start_i       (start),
    .memInRdAddr_i (memInRdAddr),
    .memOutWrEn_i  (memOutWrEn),
    .memOutWrAddr_i(memOutWrAddr),
    .memOutWrData_i(memOutWrData),
    .coreBusy_i    (coreBusy),
    .coreDone_i    (coreDone),
    .dataOut_o     (dataOut),
    .intAIP_o      (intAIP),
    .memInRdData_o (memInRdData),
    .confData_o    (confData),
    .coreStart_o   (coreStart)
  );

  always #(ClkPeriod/2) clk = ~clk;

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic checkData(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      abortRun($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abortRun($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic waitInt(input logic level);
    int cycles;
    cycles = 0;
    while (intAIP !== level && cycles < IntTimeout) begin
      @(negedge clk);
      cycles++;
    end
    if (intAIP !== level) begin
      abortRun($sformatf("Interrupt did not settle at %0b within %0d cycles",
                         level, IntTimeout));
    end
  endtask

  // Busy in bit 0, mask in bit 8, done in bit 16
  function automatic data_t statusExp(input logic busy, input logic mask, input logic done);
    return {15'd0, done, 7'd0, mask, 7'd0, busy};
  endfunction

  task automatic addStep(input op_e op, input configCode_e code, input int addr,
                         input data_t data, input data_t exp);
    opQ.push_back(op);
    codeQ.push_back(code);
    addrQ.push_back(16'(addr));
    dataQ.push_back(data);
    expQ.push_back(exp);
  endtask

  task automatic buildTable();
    data_t words [20];
    for (int k = 0; k < 20; k++) begin
      words[k] = $urandom();
    end
    // Identifier, unlisted codes, start passthrough
    addStep(OpRead, CodeId, 0, '0, ExpectedId);
    addStep(OpRead, configCode_e'(5'd7), 0, '0, '0);
    addStep(OpRead, CodeMemInAddr, 0, '0, '0);
    addStep(OpStart, CodeId, 0, 32'd1, 32'd1);
    addStep(OpStart, CodeId, 0, 32'd0, '0);
    // Input memory fill, then wrap past the top
    addStep(OpWrite, CodeMemInAddr, 0, 32'd4, '0);
    for (int k = 0; k < 4; k++) addStep(OpWrite, CodeMemInData, 0, words[k], '0);
    for (int k = 0; k < 4; k++) addStep(OpCoreRead, CodeId, 4 + k, '0, words[k]);
    addStep(OpWrite, CodeMemInAddr, 0, 32'd30, '0);
    for (int k = 4; k < 7; k++) addStep(OpWrite, CodeMemInData, 0, words[k], '0);
    for (int k = 4; k < 7; k++) begin
      addStep(OpCoreRead, CodeId, (26 + k) % MemInDepth, '0, words[k]);
    end
    // Output memory drain
    for (int k = 0; k < 5; k++) addStep(OpCoreWrite, CodeId, 10 + k, words[7 + k], '0);
    addStep(OpWrite, CodeMemOutAddr, 0, 32'd10, '0);
    for (int k = 0; k < 5; k++) addStep(OpReadNext, CodeMemOutData, 0, '0, words[7 + k]);
    addStep(OpWrite, CodeMemOutAddr, 0, 32'd12, '0);
    addStep(OpRead, CodeMemOutData, 0, '0, words[9]);
    addStep(OpRead, CodeMemOutData, 0, '0, words[9]);  // No strobe, no advance
    // Configuration bank
    addStep(OpWrite, CodeConfAddr, 0, '0, '0);
    addStep(OpWrite, CodeConfData, 0, words[12], '0);
    addStep(OpWrite, CodeConfData, 0, words[13], '0);
    addStep(OpCheckConf, CodeId, 0, '0, words[12]);
    addStep(OpCheckConf, CodeId, 1, '0, words[13]);
    addStep(OpWrite, CodeConfData, 0, words[14], '0);
    addStep(OpCheckConf, CodeId, 0, '0, words[14]);
    addStep(OpCheckConf, CodeId, 1, '0, words[13]);
    addStep(OpWrite, CodeConfAddr, 0, '0, '0);  // Pointer sits at word 1 here
    addStep(OpWrite, CodeConfData, 0, words[18], '0);
    addStep(OpCheckConf, CodeId, 0, '0, words[18]);
    addStep(OpCheckConf, CodeId, 1, '0, words[13]);
    // Status, done flag and interrupt
    addStep(OpBusy, CodeId, 0, 32'd1, '0);
    addStep(OpRead, CodeStatus, 0, '0, statusExp(1'b1, 1'b0, 1'b0));
    addStep(OpBusy, CodeId, 0, 32'd0, '0);
    addStep(OpRead, CodeStatus, 0, '0, '0);
    addStep(OpDone, CodeId, 0, '0, '0);
    addStep(OpRead, CodeStatus, 0, '0, statusExp(1'b0, 1'b0, 1'b1));
    addStep(OpCheckInt, CodeId, 0, '0, '0);
    addStep(OpCheckInt, CodeId, 0, '0, '0);  // Mask still off
    addStep(OpWrite, CodeStatus, 0, statusExp(1'b0, 1'b1, 1'b0), '0);
    addStep(OpWaitInt, CodeId, 0, '0, 32'd1);
    addStep(OpRead, CodeStatus, 0, '0, statusExp(1'b0, 1'b1, 1'b1));
    addStep(OpWrite, CodeStatus, 0, statusExp(1'b0, 1'b1, 1'b1), '0);
    addStep(OpRead, CodeStatus, 0, '0, statusExp(1'b0, 1'b1, 1'b0));
    addStep(OpWaitInt, CodeId, 0, '0, '0);
    // Pointer frozen while disabled
    addStep(OpWrite, CodeMemInAddr, 0, 32'd12, '0);
    addStep(OpEnable, CodeId, 0, 32'd0, '0);
    addStep(OpWrite, CodeMemInData, 0, words[15], '0);
    addStep(OpCoreRead, CodeId, 12, '0, words[15]);
    addStep(OpWrite, CodeMemInData, 0, words[16], '0);
    addStep(OpCoreRead, CodeId, 12, '0, words[16]);
    addStep(OpEnable, CodeId, 0, 32'd1, '0);
    addStep(OpWrite, CodeMemInData, 0, words[17], '0);
    addStep(OpCoreRead, CodeId, 12, '0, words[17]);
  endtask

  initial begin
    int confIdx;
    rst = 1'b0;
    en = 1'b1;
    hostConfig = CodeId;
    hostData = '0;
    hostWrite = 1'b0;
    hostRead = 1'b0;
    start = 1'b0;
    memInRdAddr = '0;
    memOutWrEn = 1'b0;
    memOutWrAddr = '0;
    memOutWrData = '0;
    coreBusy = 1'b0;
    coreDone = 1'b0;
    void'($urandom(RandSeed));
    buildTable();

    repeat (3) @(posedge clk);
    rst <= 1'b1;

    for (int i = 0; i < opQ.size(); i++) begin
      @(posedge clk);
      hostWrite <= 1'b0;  // Strobes last one cycle
      hostRead <= 1'b0;
      coreDone <= 1'b0;
      memOutWrEn <= 1'b0;
      start <= 1'b0;
      hostConfig <= codeQ[i];
      case (opQ[i])
        OpWrite: begin
          hostData <= dataQ[i];
          hostWrite <= 1'b1;
        end
        OpReadNext: hostRead <= 1'b1;
        OpCoreRead: memInRdAddr <= addrQ[i][MemInAddrWidth-1:0];
        OpCoreWrite: begin
          memOutWrEn <= 1'b1;
          memOutWrAddr <= addrQ[i][MemOutAddrWidth-1:0];
          memOutWrData <= dataQ[i];
        end
        OpBusy: coreBusy <= dataQ[i][0];
        OpDone: coreDone <= 1'b1;
        OpEnable: en <= dataQ[i][0];
        OpStart: start <= dataQ[i][0];
        default: ;
      endcase

      @(negedge clk);
      case (opQ[i])
        OpRead, OpReadNext: checkData("dataOut_o", dataOut, expQ[i]);
        OpCoreRead: checkData("memInRdData_o", memInRdData, expQ[i]);
        OpCheckConf: begin
          confIdx = int'(addrQ[i]);
          checkData("confData_o", confData[confIdx*DataWidth +: DataWidth], expQ[i]);
        end
        OpStart: checkBit("coreStart_o", coreStart, expQ[i][0]);
        OpCheckInt: checkBit("intAIP_o", intAIP, expQ[i][0]);
        OpWaitInt: waitInt(expQ[i][0]);
        default: ;
      endcase
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule
